/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = dram_queue_tb
FLIST    = flist.f
OBJ_DIR  = obj_dir
PASS_MSG = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The simulation passes only if the pass message shows up in its output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/dram_queue_chk.sv */
module dram_queue_chk (
   input logic clk,
   input logic reset,
   input logic in_wr,
   input logic in_rdy,
   input logic wr_req,
   input logic wr_ack,
   input logic wr_data_vld,
   input logic wr_full,
   input logic rd_req,
   input logic rd_ack,
   input logic sc_push,
   input logic rm_push
);

   // Sender stays inside the almost-full slack
   a_in_wr_rdy: assert property (@(posedge clk) disable iff (reset) in_wr |-> in_rdy)
      else $error("in_wr asserted while in_rdy low");

   a_no_vld_full: assert property (@(posedge clk) disable iff (reset) wr_data_vld |-> !wr_full)
      else $error("write data_vld during DRAM full");

   a_wr_ack_req: assert property (@(posedge clk) disable iff (reset) wr_ack |-> $past(wr_req))
      else $error("write ack without a prior req");

   a_rd_ack_req: assert property (@(posedge clk) disable iff (reset) rd_ack |-> $past(rd_req))
      else $error("read ack without a prior req");

   a_one_push: assert property (@(posedge clk) disable iff (reset) !(sc_push && rm_push))
      else $error("shortcut and remove push in the same cycle");

endmodule

bind dram_queue_top dram_queue_chk u_chk (
   .clk         (clk),
   .reset       (reset),
   .in_wr       (in_wr),
   .in_rdy      (in_rdy),
   .wr_req      (wr_if.req),
   .wr_ack      (wr_if.ack),
   .wr_data_vld (wr_if.data_vld),
   .wr_full     (wr_if.full),
   .rd_req      (rd_if.req),
   .rd_ack      (rd_if.ack),
   .sc_push     (sc_push),
   .rm_push     (rm_push)
);

/* dv/dram_queue_tb.sv */
`include "dram_q_cfg.svh"

module dram_queue_tb import dram_q_pkg::*; ();

   localparam int SETTLE_CYCLES = 800;   // Drain bound per test
   localparam int QUIET_CYCLES  = 80;
   localparam int RUN_WORDS     = 10 + 60 + 40 + 150 + 80;
   // Four times the feed and settle time of all five tests
   localparam int TIMEOUT_CYCLES = 4 * (4 * RUN_WORDS + 5 * SETTLE_CYCLES);
   // Out FIFO to almost-full, three ring blocks, input FIFO to almost-full
   localparam int HOLD_MAX = (`DQ_OUT_DEPTH - `DQ_AFULL_GAP)
                           + ((2 ** `DQ_BLK_AW) - 1) * `DQ_BLK_WORDS
                           + (`DQ_IN_DEPTH - `DQ_AFULL_GAP);

   typedef logic [$bits(pkt_word_t)-1:0] cmp_t;

   logic                  clk = 1'b0;
   logic                  reset;
   logic [`DQ_DATA_W-1:0] in_data;
   logic [`DQ_CTRL_W-1:0] in_ctrl;
   logic                  in_wr;
   logic                  in_rdy;
   logic [`DQ_DATA_W-1:0] out_data;
   logic [`DQ_CTRL_W-1:0] out_ctrl;
   logic                  out_wr;
   logic                  out_rdy;
   logic [`DQ_BLK_AW-1:0] block_lo;
   logic [`DQ_BLK_AW-1:0] block_hi;
   logic                  init;
   logic                  shortcut_disable;

   pkt_word_t exp_q [$];   // Scoreboard, oldest word first
   pkt_word_t exp_w;
   integer    seed      = 32'h7ae2;
   int        word_idx  = 0;
   int        rx_count  = 0;
   int        errors    = 0;
   int        checks    = 0;
   int        test_base = 0;
   int        tests_run = 0;
   int        cycles    = 0;
   logic      streaming;
   logic      toggling;

   dram_queue_top u_dut (
      .clk (clk), .reset (reset), .in_data (in_data), .in_ctrl (in_ctrl),
      .in_wr (in_wr), .in_rdy (in_rdy), .out_data (out_data), .out_ctrl (out_ctrl),
      .out_wr (out_wr), .out_rdy (out_rdy), .block_lo (block_lo), .block_hi (block_hi),
      .init (init), .shortcut_disable (shortcut_disable)
   );

   always #20 clk = ~clk;

   //////////////////////////////////////////////////
   // Checking and scoreboard
   //////////////////////////////////////////////////
   task automatic check_value(input string what, input cmp_t got, input cmp_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] t=%0t: %s mismatch, got %h expected %h", $time, what, got, exp);
      end
   endtask

   always @(posedge clk) begin
      if (!reset) begin
         if (!out_rdy) check_value("out_wr with out_rdy low", cmp_t'(out_wr), '0);
         if (out_wr) begin
            rx_count++;
            if (exp_q.size() == 0) begin
               errors++;
               $display("Unexpected output word %h at t=%0t, nothing was sent for it",
                        {out_ctrl, out_data}, $time);
            end else begin
               exp_w = exp_q.pop_front();
               check_value("output word", {out_ctrl, out_data}, exp_w);
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////
   task automatic make_word(output pkt_word_t w);
      w.data = {$random(seed), $random(seed)};
      // Every seventh word closes a packet
      w.ctrl = (word_idx % 7 == 6) ? (`DQ_CTRL_W'($random(seed)) | `DQ_CTRL_W'(1)) : '0;
      word_idx++;
   endtask

   // Called on a falling edge; drives a word only while in_rdy is high
   task automatic offer_word(output bit sent);
      pkt_word_t w;
      if (in_rdy) begin
         make_word(w);
         in_wr   = 1'b1;
         in_data = w.data;
         in_ctrl = w.ctrl;
         exp_q.push_back(w);
         sent = 1'b1;
      end else begin
         in_wr = 1'b0;
         sent  = 1'b0;
      end
   endtask

   task automatic drive_words(input int n);
      int cnt;
      bit ok;
      cnt = 0;
      while (cnt < n) begin
         @(negedge clk);
         offer_word(ok);
         if (ok) cnt++;
      end
      @(negedge clk);
      in_wr = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < SETTLE_CYCLES) begin
         @(negedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("Output did not drain, %0d words still missing after %0d cycles",
                  exp_q.size(), SETTLE_CYCLES);
      end
   endtask

   task automatic end_test(input string name);
      $display("test %-16s finished, %0d errors", name, errors - test_base);
      test_base = errors;
      tests_run++;
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////
   task automatic test_shortcut();
      int base;
      base = rx_count;
      drive_words(10);
      wait_drain();
      check_value("shortcut word count", cmp_t'(rx_count - base), cmp_t'(10));
      end_test("shortcut_pass");
   endtask

   task automatic test_dram_stall();
      int base;
      base    = rx_count;
      out_rdy = 1'b0;
      drive_words(60);
      repeat (QUIET_CYCLES) @(negedge clk);
      check_value("words out while stalled", cmp_t'(rx_count - base), '0);
      out_rdy = 1'b1;
      wait_drain();
      check_value("stall word count", cmp_t'(rx_count - base), cmp_t'(60));
      end_test("dram_stall");
   endtask

   task automatic test_no_shortcut();
      int base;
      int waited;
      int blk_out;
      base    = rx_count;
      blk_out = (40 / `DQ_BLK_WORDS) * `DQ_BLK_WORDS;   // Whole blocks only
      shortcut_disable = 1'b1;
      drive_words(40);
      waited = 0;
      while (rx_count - base < blk_out && waited < SETTLE_CYCLES) begin
         @(negedge clk);
         waited++;
      end
      repeat (QUIET_CYCLES) @(negedge clk);
      check_value("whole-block words out", cmp_t'(rx_count - base), cmp_t'(blk_out));
      check_value("words held back", cmp_t'(exp_q.size()), cmp_t'(40 - blk_out));
      shortcut_disable = 1'b0;
      wait_drain();
      check_value("no-shortcut word count", cmp_t'(rx_count - base), cmp_t'(40));
      end_test("no_shortcut");
   endtask

   task automatic test_backpressure();
      int base;
      int sent;
      bit ok;
      bit fell;
      base    = rx_count;
      sent    = 0;
      fell    = 1'b0;
      out_rdy = 1'b0;
      while (sent < 150 && !fell) begin
         @(negedge clk);
         offer_word(ok);
         if (ok) sent++;
         else fell = 1'b1;
      end
      if (!fell) begin
         @(negedge clk);
         in_wr = 1'b0;
         errors++;
         $display("in_rdy never fell after %0d words with the output stalled", sent);
      end
      check_value("in_rdy fell within capacity", cmp_t'(sent <= HOLD_MAX), cmp_t'(1));
      out_rdy = 1'b1;
      wait_drain();
      check_value("back-pressure word count", cmp_t'(rx_count - base), cmp_t'(sent));
      end_test("backpressure");
   endtask

   task automatic test_range_init();
      int base;
      int phase;
      base     = rx_count;
      block_lo = `DQ_BLK_AW'(1);
      block_hi = `DQ_BLK_AW'(3);
      init     = 1'b1;
      @(negedge clk);
      init      = 1'b0;
      streaming = 1'b1;
      toggling  = 1'b1;
      fork
         begin
            drive_words(80);
            streaming = 1'b0;
            wait_drain();
            toggling = 1'b0;
         end
         begin
            phase = 0;
            while (toggling) begin
               @(negedge clk);
               // Sparse drain while feeding pushes words through the ring wrap
               out_rdy = streaming ? (phase % 16 == 0) : (phase % 2 == 0);
               phase++;
            end
         end
      join
      out_rdy = 1'b1;
      check_value("range word count", cmp_t'(rx_count - base), cmp_t'(80));
      end_test("range_init");
   endtask

   initial begin
      reset            = 1'b1;
      in_data          = '0;
      in_ctrl          = '0;
      in_wr            = 1'b0;
      out_rdy          = 1'b1;
      block_lo         = '0;
      block_hi         = `DQ_BLK_AW'(3);
      init             = 1'b0;
      shortcut_disable = 1'b0;
      streaming        = 1'b0;
      toggling         = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      test_shortcut();
      test_dram_stall();
      test_no_shortcut();
      test_backpressure();
      test_range_init();

      $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* flist.f */
+incdir+include
logic/dram_q_pkg.sv
logic/dram_if.sv
logic/word_fifo.sv
logic/store_pkt_dram.sv
logic/remove_pkt_dram.sv
logic/dram_block_mem.sv
logic/dram_queue_top.sv
dv/dram_queue_chk.sv
dv/dram_queue_tb.sv

/* include/dram_q_cfg.svh */
`ifndef DRAM_Q_CFG_SVH
`define DRAM_Q_CFG_SVH

// Packet word layout
`define DQ_DATA_W      64
`define DQ_CTRL_W      8

// DRAM ring geometry
`define DQ_BLK_AW      2     // Four blocks in the ring
`define DQ_BLK_WORDS   16
`define DQ_DRAM_AW     6     // Block index plus word offset

// On-chip buffering
`define DQ_IN_DEPTH    64
`define DQ_OUT_DEPTH   32
`define DQ_AFULL_GAP   2
`define DQ_FULL_EVERY  5     // Accepted words between DRAM stalls

`endif

/* logic/dram_block_mem.sv */
`include "dram_q_cfg.svh"

module dram_block_mem import dram_q_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   dram_wr_if.slave wr,
   dram_rd_if.slave rd
);

   localparam int OFF_W  = $clog2(`DQ_BLK_WORDS);
   localparam int FCNT_W = $clog2(`DQ_FULL_EVERY);

   typedef enum logic [1:0] {
      M_IDLE,
      M_WR,
      M_RD
   } state_t;

   state_t                  state;
   pkt_word_t               mem [2**`DQ_DRAM_AW];
   blk_addr_t               ptr_q;
   logic [OFF_W-1:0]        off;
   logic [FCNT_W-1:0]       full_cnt;
   logic [`DQ_DRAM_AW-1:0]  word_addr;
   logic                    last_off;
   logic                    wr_acc;

   assign word_addr = {ptr_q, off};
   assign last_off  = (off == OFF_W'(`DQ_BLK_WORDS - 1));
   assign wr_acc    = (state == M_WR) && wr.data_vld;
   assign wr.done   = wr_acc && last_off;   // Same cycle as the final word

   //////////////////////////////////////////////////
   // Storage and read data
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (wr_acc) mem[word_addr] <= wr.data;
      rd.data <= mem[word_addr];
      if (state == M_IDLE) ptr_q <= wr.req ? wr.ptr : rd.ptr;   // Write side wins
   end

   //////////////////////////////////////////////////
   // Burst control
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= M_IDLE;
         off         <= '0;
         wr.ack      <= 1'b0;
         rd.ack      <= 1'b0;
         rd.data_vld <= 1'b0;
         rd.done     <= 1'b0;
      end else begin
         wr.ack      <= 1'b0;
         rd.ack      <= 1'b0;
         rd.data_vld <= 1'b0;
         rd.done     <= 1'b0;
         case (state)
            M_IDLE: begin
               off <= '0;
               if (wr.req) begin
                  wr.ack <= 1'b1;
                  state  <= M_WR;
               end else if (rd.req) begin
                  rd.ack <= 1'b1;
                  state  <= M_RD;
               end
            end
            M_WR: begin
               if (wr_acc) begin
                  off <= off + 1'b1;
                  if (last_off) state <= M_IDLE;
               end
            end
            M_RD: begin
               // One word per cycle, first one the cycle after ack
               rd.data_vld <= 1'b1;
               rd.done     <= last_off;
               off         <= off + 1'b1;
               if (last_off) state <= M_IDLE;
            end
            default: state <= M_IDLE;
         endcase
      end
   end

   // Periodic write stall, one cycle after every DQ_FULL_EVERY words
   always_ff @(posedge clk) begin
      if (reset) begin
         full_cnt <= '0;
         wr.full  <= 1'b0;
      end else if (wr_acc && full_cnt == FCNT_W'(`DQ_FULL_EVERY - 1)) begin
         full_cnt <= '0;
         wr.full  <= 1'b1;
      end else begin
         if (wr_acc) full_cnt <= full_cnt + 1'b1;
         wr.full <= 1'b0;
      end
   end

endmodule

/* logic/dram_if.sv */
// Block write channel, store engine to DRAM
interface dram_wr_if import dram_q_pkg::*; ();
   logic      req;
   logic      ack;
   blk_addr_t ptr;
   logic      data_vld;
   pkt_word_t data;
   logic      full;       // One-cycle stall from the memory
   logic      done;       // Rides on the last accepted word

   modport master (output req, ptr, data_vld, data, input ack, full, done);
   modport slave  (input req, ptr, data_vld, data, output ack, full, done);
endinterface

// Block read channel, DRAM to remove engine
interface dram_rd_if import dram_q_pkg::*; ();
   logic      req;
   logic      ack;
   blk_addr_t ptr;
   logic      data_vld;
   pkt_word_t data;
   logic      done;

   modport master (output req, ptr, input ack, data_vld, data, done);
   modport slave  (input req, ptr, output ack, data_vld, data, done);
endinterface

/* logic/dram_q_pkg.sv */
`include "dram_q_cfg.svh"

package dram_q_pkg;

   // One FIFO word, ctrl in the upper byte
   typedef struct packed {
      logic [`DQ_CTRL_W-1:0] ctrl;    // Non-zero on last word of packet
      logic [`DQ_DATA_W-1:0] data;
   } pkt_word_t;

   // Block index into the DRAM ring
   typedef logic [`DQ_BLK_AW-1:0] blk_addr_t;

endpackage

/* logic/dram_queue_top.sv */
`include "dram_q_cfg.svh"

module dram_queue_top import dram_q_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [`DQ_DATA_W-1:0] in_data,
   input  logic [`DQ_CTRL_W-1:0] in_ctrl,
   input  logic                  in_wr,
   output logic                  in_rdy,
   output logic [`DQ_DATA_W-1:0] out_data,
   output logic [`DQ_CTRL_W-1:0] out_ctrl,
   output logic                  out_wr,
   input  logic                  out_rdy,
   input  logic [`DQ_BLK_AW-1:0] block_lo,
   input  logic [`DQ_BLK_AW-1:0] block_hi,
   input  logic                  init,
   input  logic                  shortcut_disable
);

   pkt_word_t in_word;
   pkt_word_t sc_word;
   pkt_word_t rm_word;
   pkt_word_t out_din;
   pkt_word_t out_dout;
   blk_addr_t wr_addr;
   blk_addr_t rd_addr;
   logic      remove_idle;
   logic      sc_push;
   logic      rm_push;
   logic      out_push;
   logic      out_empty;
   logic      out_afull;
   logic [$clog2(`DQ_OUT_DEPTH+1)-1:0] out_count;

   dram_wr_if wr_if ();
   dram_rd_if rd_if ();

   assign in_word = '{ctrl: in_ctrl, data: in_data};

   // Shortcut needs remove idle, so the two pushes never overlap
   assign out_push = sc_push | rm_push;
   assign out_din  = sc_push ? sc_word : rm_word;

   assign out_wr   = out_rdy && !out_empty;
   assign out_data = out_dout.data;
   assign out_ctrl = out_dout.ctrl;

   store_pkt_dram u_store (
      .clk (clk), .reset (reset), .in_word (in_word), .in_wr (in_wr), .in_rdy (in_rdy),
      .block_lo (block_lo), .block_hi (block_hi), .init (init),
      .shortcut_disable (shortcut_disable), .rd_addr (rd_addr), .remove_idle (remove_idle),
      .out_afull (out_afull), .out_push (sc_push), .out_word (sc_word),
      .wr_addr (wr_addr), .dram (wr_if.master)
   );

   remove_pkt_dram u_remove (
      .clk (clk), .reset (reset), .block_lo (block_lo), .block_hi (block_hi), .init (init),
      .wr_addr (wr_addr), .rd_addr (rd_addr), .remove_idle (remove_idle),
      .out_count (out_count), .out_push (rm_push), .out_word (rm_word), .dram (rd_if.master)
   );

   dram_block_mem u_mem (.clk (clk), .reset (reset), .wr (wr_if.slave), .rd (rd_if.slave));

   word_fifo #(.T (pkt_word_t), .DEPTH (`DQ_OUT_DEPTH)) u_out_fifo (
      .clk (clk), .reset (reset), .push (out_push), .din (out_din), .pop (out_wr),
      .dout (out_dout), .empty (out_empty), .afull (out_afull), .count (out_count)
   );

endmodule

/* logic/remove_pkt_dram.sv */
`include "dram_q_cfg.svh"

module remove_pkt_dram import dram_q_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  blk_addr_t block_lo,
   input  blk_addr_t block_hi,
   input  logic      init,
   input  blk_addr_t wr_addr,
   output blk_addr_t rd_addr,
   output logic      remove_idle,
   // Output FIFO side
   input  logic [$clog2(`DQ_OUT_DEPTH+1)-1:0] out_count,
   output logic      out_push,
   output pkt_word_t out_word,
   dram_rd_if.master dram
);

   // Highest fill that still takes a whole block
   localparam int ROOM_MAX = `DQ_OUT_DEPTH - `DQ_BLK_WORDS;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_READ
   } state_t;

   state_t    state;
   state_t    state_nxt;
   blk_addr_t lo_q;
   blk_addr_t hi_q;
   blk_addr_t rd_addr_inc;
   logic      blk_stored;
   logic      out_room;
   logic      adv_ptr;

   assign rd_addr_inc = (rd_addr >= hi_q) ? lo_q : blk_addr_t'(rd_addr + 1'b1);
   assign blk_stored  = (rd_addr != wr_addr);
   assign out_room    = (out_count <= ROOM_MAX);
   assign remove_idle = (state == ST_IDLE);

   assign dram.ptr = rd_addr;
   assign out_word = dram.data;

   always_comb begin
      state_nxt = state;
      dram.req  = 1'b0;
      out_push  = 1'b0;
      adv_ptr   = 1'b0;
      case (state)
         ST_IDLE: begin
            if (blk_stored && out_room) state_nxt = ST_REQ;
         end
         ST_REQ: begin
            dram.req = 1'b1;
            if (dram.ack) state_nxt = ST_READ;
         end
         ST_READ: begin
            // Room was reserved before the request
            out_push = dram.data_vld;
            if (dram.data_vld && dram.done) begin
               state_nxt = ST_IDLE;
               adv_ptr   = 1'b1;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      lo_q <= block_lo;
      hi_q <= block_hi;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= ST_IDLE;
         rd_addr <= '0;
      end else begin
         state <= state_nxt;
         if (init)         rd_addr <= block_lo;
         else if (adv_ptr) rd_addr <= rd_addr_inc;   // Wraps hi back to lo
      end
   end

endmodule

/* logic/store_pkt_dram.sv */
`include "dram_q_cfg.svh"

module store_pkt_dram import dram_q_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   // Packet input
   input  pkt_word_t in_word,
   input  logic      in_wr,
   output logic      in_rdy,
   // Ring range and control
   input  blk_addr_t block_lo,
   input  blk_addr_t block_hi,
   input  logic      init,
   input  logic      shortcut_disable,
   // Remove side
   input  blk_addr_t rd_addr,
   input  logic      remove_idle,
   // Shortcut into output FIFO
   input  logic      out_afull,
   output logic      out_push,
   output pkt_word_t out_word,
   output blk_addr_t wr_addr,
   dram_wr_if.master dram
);

   typedef enum logic [1:0] {
      ST_WAIT_DATA,
      ST_REQ,
      ST_WRITE,
      ST_WAIT_NOT_FULL
   } state_t;

   state_t    state;
   state_t    state_nxt;
   pkt_word_t fifo_dout;
   logic      fifo_pop;
   logic      fifo_empty;
   logic      fifo_afull;
   logic [$clog2(`DQ_IN_DEPTH+1)-1:0] fifo_count;
   blk_addr_t lo_q;
   blk_addr_t hi_q;
   blk_addr_t wr_addr_inc;
   logic      sc_dis_q;
   logic      ring_empty;
   logic      ring_full;
   logic      blk_avail;
   logic      shortcut_rdy;
   logic      adv_ptr;

   //////////////////////////////////////////////////
   // Input buffer
   //////////////////////////////////////////////////
   word_fifo #(
      .T     (pkt_word_t),
      .DEPTH (`DQ_IN_DEPTH)
   ) u_in_fifo (
      .clk   (clk),
      .reset (reset),
      .push  (in_wr),
      .din   (in_word),
      .pop   (fifo_pop),
      .dout  (fifo_dout),
      .empty (fifo_empty),
      .afull (fifo_afull),
      .count (fifo_count)
   );

   assign in_rdy = !fifo_afull;   // Leaves DQ_AFULL_GAP words of slack

   //////////////////////////////////////////////////
   // Ring status
   //////////////////////////////////////////////////
   assign wr_addr_inc = (wr_addr >= hi_q) ? lo_q : blk_addr_t'(wr_addr + 1'b1);
   assign ring_empty  = (wr_addr == rd_addr);
   assign ring_full   = (wr_addr_inc == rd_addr);
   assign blk_avail   = (fifo_count >= `DQ_BLK_WORDS);

   // Bypass DRAM only when nothing is stored or in flight
   assign shortcut_rdy = !fifo_empty && !sc_dis_q && !out_afull
                         && ring_empty && remove_idle;

   assign dram.ptr  = wr_addr;
   assign dram.data = fifo_dout;
   assign out_word  = fifo_dout;

   always_comb begin
      state_nxt     = state;
      fifo_pop      = 1'b0;
      out_push      = 1'b0;
      dram.req      = 1'b0;
      dram.data_vld = 1'b0;
      adv_ptr       = 1'b0;
      case (state)
         ST_WAIT_DATA: begin
            if (shortcut_rdy) begin
               out_push = 1'b1;
               fifo_pop = 1'b1;
            end else if (blk_avail && !ring_full) begin
               state_nxt = ST_REQ;
            end
         end
         ST_REQ: begin
            dram.req = 1'b1;   // Held until ack
            if (dram.ack) state_nxt = ST_WRITE;
         end
         ST_WRITE: begin
            if (dram.full) begin
               state_nxt = ST_WAIT_NOT_FULL;
            end else begin
               dram.data_vld = 1'b1;
               fifo_pop      = 1'b1;
               if (dram.done) begin
                  state_nxt = ST_WAIT_DATA;
                  adv_ptr   = 1'b1;
               end
            end
         end
         ST_WAIT_NOT_FULL: begin
            if (!dram.full) state_nxt = ST_WRITE;
         end
         default: state_nxt = ST_WAIT_DATA;
      endcase
   end

   // Range and shortcut enable sampled every cycle
   always_ff @(posedge clk) begin
      lo_q     <= block_lo;
      hi_q     <= block_hi;
      sc_dis_q <= shortcut_disable;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= ST_WAIT_DATA;
         wr_addr <= '0;
      end else begin
         state <= state_nxt;
         if (init)         wr_addr <= block_lo;
         else if (adv_ptr) wr_addr <= wr_addr_inc;
      end
   end

endmodule

/* logic/word_fifo.sv */
`include "dram_q_cfg.svh"

module word_fifo #(
   parameter type T     = logic [7:0],
   parameter int  DEPTH = 16
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       push,
   input  T                           din,
   input  logic                       pop,
   output T                           dout,
   output logic                       empty,
   output logic                       afull,
   output logic [$clog2(DEPTH+1)-1:0] count
);

   localparam int PW = $clog2(DEPTH);

   T               mem [DEPTH];
   logic [PW-1:0]  wr_ptr;
   logic [PW-1:0]  rd_ptr;
   logic           full;
   logic           do_push;
   logic           do_pop;

   assign full    = (count == DEPTH);
   assign empty   = (count == 0);
   assign afull   = (count >= DEPTH - `DQ_AFULL_GAP);
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   // Head word visible while not empty
   assign dout = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= din;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
         if (do_push && !do_pop)      count <= count + 1'b1;
         else if (do_pop && !do_push) count <= count - 1'b1;
      end
   end

endmodule
